/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	localparam int WORD_BITS      = 32;
	localparam int REG_ADDR_BITS  = 5;
	localparam int IMEM_ADDR_BITS = 6; // 64 instruction words
	localparam int DMEM_ADDR_BITS = 6;

	typedef logic [WORD_BITS-1:0]     word_t;
	typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

	// Primary opcodes, insn[31:26]
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function codes, insn[5:0]
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;

	// ALU operations
	// Shifts take the amount in operand a and the value in operand b
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,    // signed compare
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B  // LUI
	} alu_op_t;

endpackage

`default_nettype wire

/* rtl/word_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module word_memory #(
	parameter int ADDR_BITS = mips_pkg::IMEM_ADDR_BITS
) (
	input  logic                 clock,
	input  logic                 write_en,
	input  logic [ADDR_BITS-1:0] write_addr,
	input  mips_pkg::word_t      write_data,
	input  logic [ADDR_BITS-1:0] read_addr,
	output mips_pkg::word_t      read_data
);
	import mips_pkg::*;

	word_t mem [2**ADDR_BITS];

	always_ff @(posedge clock) begin
		if (write_en)
			mem[write_addr] <= write_data;
	end

	// Asynchronous read port
	assign read_data = mem[read_addr];

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
	input  logic                                clock,
	input  logic                                arst_n,
	input  logic                                run,
	input  logic                                imem_load,
	input  logic [mips_pkg::IMEM_ADDR_BITS-1:0] imem_addr,
	input  mips_pkg::word_t                     imem_data,
	output logic                                fd_valid,
	output mips_pkg::word_t                     fd_insn
);
	import mips_pkg::*;

	logic [IMEM_ADDR_BITS-1:0] pc;
	logic                      last_issued; // Top word already sent
	logic                      issue;
	word_t                     imem_word;

	assign issue = run && !last_issued;

	word_memory #(.ADDR_BITS(IMEM_ADDR_BITS)) u_imem (
		.clock      (clock),
		.write_en   (imem_load),
		.write_addr (imem_addr),
		.write_data (imem_data),
		.read_addr  (pc),
		.read_data  (imem_word)
	);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= '0;
			last_issued <= 1'b0;
			fd_valid    <= 1'b0;
		end else begin
			fd_valid <= issue;
			if (issue) begin
				pc <= pc + 1'b1;
				if (&pc)
					last_issued <= 1'b1; // stop after word 63
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue)
			fd_insn <= imem_word;
	end

	// Program is loaded only before the core runs
	a_no_load_while_running: assert property (
		@(posedge clock) disable iff (!arst_n) !(imem_load && run)
	);

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  write_en,
	input  mips_pkg::reg_addr_t   write_reg,
	input  mips_pkg::word_t       write_value,
	input  mips_pkg::reg_addr_t   read_reg_a,
	input  mips_pkg::reg_addr_t   read_reg_b,
	output mips_pkg::word_t       read_a,
	output mips_pkg::word_t       read_b
);
	import mips_pkg::*;

	word_t regs [2**REG_ADDR_BITS];

	// Same-cycle write is visible to the reader
	function automatic word_t port_read(input reg_addr_t idx);
		if (idx == '0)
			return '0;
		else if (write_en && write_reg == idx)
			return write_value;
		else
			return regs[idx];
	endfunction

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**REG_ADDR_BITS; i++)
				regs[i] <= '0;
		end else if (write_en && write_reg != '0) begin
			regs[write_reg] <= write_value; // r0 never written
		end
	end

	assign read_a = port_read(read_reg_a);
	assign read_b = port_read(read_reg_b);

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  fd_valid,
	input  mips_pkg::word_t       fd_insn,
	input  logic                  wb_valid,
	input  mips_pkg::reg_addr_t   wb_reg,
	input  mips_pkg::word_t       wb_value,
	output logic                  de_valid,
	output mips_pkg::alu_op_t     de_alu_op,
	output mips_pkg::word_t       de_a,
	output mips_pkg::word_t       de_b,
	output mips_pkg::word_t       de_store_data,
	output mips_pkg::reg_addr_t   de_dest,
	output logic                  de_writes,
	output logic                  de_load,
	output logic                  de_store
);
	import mips_pkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	logic [15:0] imm;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	word_t       rs_value;
	word_t       rt_value;

	alu_op_t     alu_op;
	reg_addr_t   dest;
	word_t       imm_ext;
	logic        writes;
	logic        load;
	logic        store;
	logic        use_imm;
	logic        shift;

	assign opcode = fd_insn[31:26];
	assign rs     = fd_insn[25:21];
	assign rt     = fd_insn[20:16];
	assign rd     = fd_insn[15:11];
	assign shamt  = fd_insn[10:6];
	assign funct  = fd_insn[5:0];
	assign imm    = fd_insn[15:0];

	register_file u_regs (
		.clock       (clock),
		.arst_n      (arst_n),
		.write_en    (wb_valid),
		.write_reg   (wb_reg),
		.write_value (wb_value),
		.read_reg_a  (rs),
		.read_reg_b  (rt),
		.read_a      (rs_value),
		.read_b      (rt_value)
	);

	always_comb begin
		alu_op  = ALU_ADD;
		dest    = rt;
		imm_ext = {{16{imm[15]}}, imm};
		writes  = 1'b0;
		load    = 1'b0;
		store   = 1'b0;
		use_imm = 1'b0;
		shift   = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dest   = rd;
				writes = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLL: begin
						alu_op = ALU_SLL;
						shift  = 1'b1;
					end
					FN_SRL: begin
						alu_op = ALU_SRL;
						shift  = 1'b1;
					end
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				use_imm = 1'b1;
				writes  = 1'b1;
			end
			OP_ORI: begin
				alu_op  = ALU_OR;
				imm_ext = {16'h0000, imm}; // zero extended
				use_imm = 1'b1;
				writes  = 1'b1;
			end
			OP_LUI: begin
				alu_op  = ALU_PASS_B;
				imm_ext = {imm, 16'h0000};
				use_imm = 1'b1;
				writes  = 1'b1;
			end
			OP_LW: begin
				use_imm = 1'b1;
				writes  = 1'b1;
				load    = 1'b1;
			end
			OP_SW: begin
				use_imm = 1'b1;
				store   = 1'b1;
			end
			default: ; // Executes as a NOP
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			de_valid  <= 1'b0;
			de_writes <= 1'b0;
			de_load   <= 1'b0;
			de_store  <= 1'b0;
		end else begin
			de_valid  <= fd_valid;
			de_writes <= fd_valid && writes && dest != '0;
			de_load   <= fd_valid && load;
			de_store  <= fd_valid && store;
		end
	end

	always_ff @(posedge clock) begin
		de_alu_op     <= alu_op;
		de_a          <= shift ? word_t'(shamt) : rs_value;
		de_b          <= use_imm ? imm_ext : rt_value;
		de_store_data <= rt_value;
		de_dest       <= dest;
	end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  de_valid,
	input  mips_pkg::alu_op_t     de_alu_op,
	input  mips_pkg::word_t       de_a,
	input  mips_pkg::word_t       de_b,
	input  mips_pkg::word_t       de_store_data,
	input  mips_pkg::reg_addr_t   de_dest,
	input  logic                  de_writes,
	input  logic                  de_load,
	input  logic                  de_store,
	output logic                  em_valid,
	output mips_pkg::word_t       em_result,
	output mips_pkg::word_t       em_store_data,
	output mips_pkg::reg_addr_t   em_dest,
	output logic                  em_writes,
	output logic                  em_load,
	output logic                  em_store
);
	import mips_pkg::*;

	word_t      result;
	logic [4:0] shamt;

	assign shamt = de_a[4:0];

	always_comb begin
		case (de_alu_op)
			ALU_ADD:    result = de_a + de_b;
			ALU_SUB:    result = de_a - de_b;
			ALU_AND:    result = de_a & de_b;
			ALU_OR:     result = de_a | de_b;
			ALU_XOR:    result = de_a ^ de_b;
			ALU_NOR:    result = ~(de_a | de_b);
			ALU_SLT:    result = word_t'($signed(de_a) < $signed(de_b));
			ALU_SLL:    result = de_b << shamt;
			ALU_SRL:    result = de_b >> shamt; // logical
			ALU_PASS_B: result = de_b;
			default:    result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			em_valid  <= 1'b0;
			em_writes <= 1'b0;
			em_load   <= 1'b0;
			em_store  <= 1'b0;
		end else begin
			em_valid  <= de_valid;
			em_writes <= de_valid && de_writes;
			em_load   <= de_valid && de_load;
			em_store  <= de_valid && de_store;
		end
	end

	always_ff @(posedge clock) begin
		em_result     <= result;
		em_store_data <= de_store_data;
		em_dest       <= de_dest;
	end

	// Decode never marks one instruction as both load and store
	a_load_store_exclusive: assert property (
		@(posedge clock) disable iff (!arst_n) !(de_load && de_store)
	);

endmodule

`default_nettype wire

/* rtl/memory_access.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_access (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  em_valid,
	input  mips_pkg::word_t       em_result,
	input  mips_pkg::word_t       em_store_data,
	input  mips_pkg::reg_addr_t   em_dest,
	input  logic                  em_writes,
	input  logic                  em_load,
	input  logic                  em_store,
	output logic                  wb_valid,
	output mips_pkg::reg_addr_t   wb_reg,
	output mips_pkg::word_t       wb_value
);
	import mips_pkg::*;

	logic [DMEM_ADDR_BITS-1:0] dmem_addr;
	logic                      store_en;
	word_t                     load_word;

	// Byte address, low two bits dropped
	assign dmem_addr = em_result[DMEM_ADDR_BITS+1:2];
	assign store_en  = em_valid && em_store;

	word_memory #(.ADDR_BITS(DMEM_ADDR_BITS)) u_dmem (
		.clock      (clock),
		.write_en   (store_en),
		.write_addr (dmem_addr),
		.write_data (em_store_data),
		.read_addr  (dmem_addr),
		.read_data  (load_word)
	);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= em_valid && em_writes;
	end

	always_ff @(posedge clock) begin
		wb_reg   <= em_dest;
		wb_value <= em_load ? load_word : em_result;
	end

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  logic                                clock,
	input  logic                                arst_n,
	input  logic                                imem_load,
	input  logic [mips_pkg::IMEM_ADDR_BITS-1:0] imem_addr,
	input  mips_pkg::word_t                     imem_data,
	input  logic                                run,
	output logic                                wb_valid,
	output mips_pkg::reg_addr_t                 wb_reg,
	output mips_pkg::word_t                     wb_value
);
	import mips_pkg::*;

	logic      fd_valid;
	word_t     fd_insn;

	logic      de_valid;
	alu_op_t   de_alu_op;
	word_t     de_a;
	word_t     de_b;
	word_t     de_store_data;
	reg_addr_t de_dest;
	logic      de_writes;
	logic      de_load;
	logic      de_store;

	logic      em_valid;
	word_t     em_result;
	word_t     em_store_data;
	reg_addr_t em_dest;
	logic      em_writes;
	logic      em_load;
	logic      em_store;

	fetch_unit u_fetch (
		.clock     (clock),
		.arst_n    (arst_n),
		.run       (run),
		.imem_load (imem_load),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.fd_valid  (fd_valid),
		.fd_insn   (fd_insn)
	);

	// Writeback feeds the register file inside decode
	decode_unit u_decode (
		.clock         (clock),
		.arst_n        (arst_n),
		.fd_valid      (fd_valid),
		.fd_insn       (fd_insn),
		.wb_valid      (wb_valid),
		.wb_reg        (wb_reg),
		.wb_value      (wb_value),
		.de_valid      (de_valid),
		.de_alu_op     (de_alu_op),
		.de_a          (de_a),
		.de_b          (de_b),
		.de_store_data (de_store_data),
		.de_dest       (de_dest),
		.de_writes     (de_writes),
		.de_load       (de_load),
		.de_store      (de_store)
	);

	execute_unit u_execute (
		.clock         (clock),
		.arst_n        (arst_n),
		.de_valid      (de_valid),
		.de_alu_op     (de_alu_op),
		.de_a          (de_a),
		.de_b          (de_b),
		.de_store_data (de_store_data),
		.de_dest       (de_dest),
		.de_writes     (de_writes),
		.de_load       (de_load),
		.de_store      (de_store),
		.em_valid      (em_valid),
		.em_result     (em_result),
		.em_store_data (em_store_data),
		.em_dest       (em_dest),
		.em_writes     (em_writes),
		.em_load       (em_load),
		.em_store      (em_store)
	);

	memory_access u_mem (
		.clock         (clock),
		.arst_n        (arst_n),
		.em_valid      (em_valid),
		.em_result     (em_result),
		.em_store_data (em_store_data),
		.em_dest       (em_dest),
		.em_writes     (em_writes),
		.em_load       (em_load),
		.em_store      (em_store),
		.wb_valid      (wb_valid),
		.wb_reg        (wb_reg),
		.wb_value      (wb_value)
	);

endmodule

`default_nettype wire

/* verification/wb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_checker (
	input  logic                clock,
	input  logic                run,
	input  logic                wb_valid,
	input  mips_pkg::reg_addr_t wb_reg,
	input  mips_pkg::word_t     wb_value,
	input  logic                run_done,
	output int                  value_errors,
	output int                  other_errors,
	output int                  wb_count,
	output logic                report_done
);
	import mips_pkg::*;

	localparam string VECTOR_FILE = "verification/core_vectors.txt";
	localparam int    FIRST_WB_EDGE = 3; // word 0 leaves memory access on edge 3

	reg_addr_t exp_reg [$];
	word_t     exp_value [$];
	string     exp_name [$];

	int   load_errors   = 0;
	int   stream_errors = 0;
	int   mismatches    = 0;
	int   writebacks    = 0;
	int   run_edge      = -1; // Posedges since run first sampled high
	logic done_seen     = 1'b0;
	logic done_flag     = 1'b0;

	assign value_errors = mismatches;
	assign other_errors = load_errors + stream_errors;
	assign wb_count     = writebacks;
	assign report_done  = done_flag;

	initial begin : load_expected
		int          fd;
		int          fields;
		string       line;
		string       tag;
		string       name;
		logic [31:0] reg_num;
		logic [31:0] value;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			load_errors++;
			$display("ERROR: checker cannot open %s", VECTOR_FILE);
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					fields = $sscanf(line, "%s %h %h %s", tag, reg_num, value, name);
					if (fields == 4 && tag == "E") begin
						exp_reg.push_back(reg_addr_t'(reg_num));
						exp_value.push_back(value);
						exp_name.push_back(name);
					end
				end
			end
			$fclose(fd);
			if (exp_reg.size() == 0) begin
				load_errors++;
				$display("ERROR: no expected writebacks found in %s", VECTOR_FILE);
			end
		end
	end

	always @(posedge clock) begin
		done_seen <= run_done;
		if (run_edge >= 0)
			run_edge <= run_edge + 1;
		else if (run === 1'b1)
			run_edge <= 0; // edge 0
	end

	task automatic compare_writeback();
		reg_addr_t e_reg;
		word_t     e_value;
		string     e_name;
		if (writebacks == 0 && run_edge != FIRST_WB_EDGE) begin
			mismatches++;
			$display("[FAIL] first_wb_edge expected %0d actual %0d", FIRST_WB_EDGE, run_edge);
		end
		if (exp_reg.size() == 0) begin
			stream_errors++;
			$display("ERROR: writeback to r%0d value %h with no expected entry left",
				wb_reg, wb_value);
		end else begin
			e_reg   = exp_reg.pop_front();
			e_value = exp_value.pop_front();
			e_name  = exp_name.pop_front();
			if (wb_reg !== e_reg) begin
				mismatches++;
				$display("[FAIL] %s register expected r%0d actual r%0d", e_name, e_reg, wb_reg);
			end
			if (wb_value !== e_value) begin
				mismatches++;
				$display("[FAIL] %s value expected %h actual %h", e_name, e_value, wb_value);
			end
		end
		writebacks++;
	endtask

	// Outputs settle after the rising edge
	always @(negedge clock) begin
		if (wb_valid !== 1'b0 && wb_valid !== 1'b1) begin
			stream_errors++;
			$display("ERROR: wb_valid is unknown at %0t", $time);
		end else if (run_edge < 0 && wb_valid) begin
			stream_errors++;
			$display("ERROR: writeback before the core was started, at %0t", $time);
		end else if (wb_valid) begin
			compare_writeback();
		end
		if (done_seen && !done_flag) begin
			if (exp_reg.size() != 0) begin
				stream_errors += exp_reg.size();
				$display("ERROR: %0d expected writebacks never happened, first missing is %s",
					exp_reg.size(), exp_name[0]);
			end
			done_flag = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verification/mips_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core_tb;
	import mips_pkg::*;

	localparam int    CLOCK_PERIOD   = 40;
	localparam int    RESET_CYCLES   = 4;
	localparam int    RUN_CYCLES     = 64 + 8;
	localparam int    REPORT_TIMEOUT = 20; // cycles
	localparam int    IMEM_WORDS     = 2**IMEM_ADDR_BITS;
	localparam string VECTOR_FILE    = "verification/core_vectors.txt";

	logic                      clock = 1'b0;
	logic                      arst_n;
	logic                      imem_load;
	logic [IMEM_ADDR_BITS-1:0] imem_addr;
	word_t                     imem_data;
	logic                      run;
	logic                      wb_valid;
	reg_addr_t                 wb_reg;
	word_t                     wb_value;

	logic  run_done;
	int    value_errors;
	int    other_errors;
	int    wb_count;
	logic  report_done;
	int    tb_errors;
	word_t program_words [IMEM_WORDS];

	mips_core u_dut (
		.clock     (clock),
		.arst_n    (arst_n),
		.imem_load (imem_load),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.run       (run),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_value  (wb_value)
	);

	wb_checker u_checker (
		.clock        (clock),
		.run          (run),
		.wb_valid     (wb_valid),
		.wb_reg       (wb_reg),
		.wb_value     (wb_value),
		.run_done     (run_done),
		.value_errors (value_errors),
		.other_errors (other_errors),
		.wb_count     (wb_count),
		.report_done  (report_done)
	);

	initial begin
		forever #(CLOCK_PERIOD/2) clock = ~clock;
	end

	// Missing words stay zero, which decodes as a NOP
	task automatic read_program();
		int          fd;
		int          fields;
		string       line;
		string       tag;
		logic [31:0] addr;
		logic [31:0] data;
		for (int i = 0; i < IMEM_WORDS; i++)
			program_words[i] = '0;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			tb_errors++;
			$display("ERROR: cannot open %s", VECTOR_FILE);
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%s %h %h", tag, addr, data);
				if (fields == 3 && tag == "I" && addr < IMEM_WORDS)
					program_words[addr] = data;
			end
		end
		$fclose(fd);
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem_load = 1'b1;
			imem_addr = i[IMEM_ADDR_BITS-1:0];
			imem_data = program_words[i];
			@(negedge clock);
		end
		imem_load = 1'b0;
	endtask

	task automatic wait_for_report(output bit finished);
		int cycles;
		cycles = 0;
		while (!report_done && cycles < REPORT_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		finished = report_done;
	endtask

	initial begin : main
		bit finished;
		arst_n    = 1'b0;
		imem_load = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		run       = 1'b0;
		run_done  = 1'b0;
		tb_errors = 0;
		read_program();
		repeat (RESET_CYCLES) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);
		load_program();
		@(negedge clock);
		run = 1'b1;
		repeat (RUN_CYCLES) @(negedge clock);
		run      = 1'b0;
		run_done = 1'b1;
		wait_for_report(finished);
		if (!finished) begin
			tb_errors++;
			$display("ERROR: checker gave no report within %0d cycles", REPORT_TIMEOUT);
		end
		$display("Errors: %0d value, %0d other, %0d testbench (%0d writebacks seen)",
			value_errors, other_errors, tb_errors, wb_count);
		if (value_errors + other_errors + tb_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/core_vectors.txt */
# I <word address hex> <instruction hex> [mnemonic]
# E <register hex> <expected writeback value hex> <test name>
I 00 24010005 addiu r1, r0, 5
E 01 00000005 addiu_pos
I 01 2402FFFD addiu r2, r0, -3
E 02 FFFFFFFD addiu_neg
I 02 34038001 ori r3, r0, 0x8001
E 03 00008001 ori_bit15
I 03 3C041234 lui r4, 0x1234
E 04 12340000 lui
I 04 340500FF ori r5, r0, 0x00ff
E 05 000000FF ori_low
I 05 24000007 addiu r0, r0, 7
I 08 00223021 addu r6, r1, r2
E 06 00000002 addu
I 09 00223823 subu r7, r1, r2
E 07 00000008 subu
I 0A 00654024 and r8, r3, r5
E 08 00000001 and
I 0B 00644825 or r9, r3, r4
E 09 12348001 or
I 0C 00855026 xor r10, r4, r5
E 0A 123400FF xor
I 0D 00255827 nor r11, r1, r5
E 0B FFFFFF00 nor
I 0E 0041602A slt r12, r2, r1
E 0C 00000001 slt_neg
I 0F 0022682A slt r13, r1, r2
E 0D 00000000 slt_false
I 10 00057100 sll r14, r5, 4
E 0E 00000FF0 sll
I 11 00027F02 srl r15, r2, 28
E 0F 0000000F srl
I 12 00210021 addu r0, r1, r1
I 13 AC290003 sw r9, 3(r1)
I 14 AC0C0010 sw r12, 16(r0)
I 16 8C100008 lw r16, 8(r0)
E 10 12348001 lw_store
I 17 8C31000C lw r17, 12(r1)
E 11 00000001 lw_offset
I 18 00039021 addu r18, r0, r3
E 12 00008001 read_r0
I 19 00009825 or r19, r0, r0
E 13 00000000 or_r0
I 1A 24140010 addiu r20, r0, 0x10
E 14 00000010 addiu_chain_a
I 1E 26950001 addiu r21, r20, 1
E 15 00000011 addiu_chain_b
I 1F FC1F1234 unknown opcode
I 20 00223008 unknown function code
I 24 00C0B021 addu r22, r6, r0
E 16 00000002 r6_kept

/* files.f */
rtl/mips_pkg.sv
rtl/word_memory.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_access.sv
rtl/mips_core.sv
verification/wb_checker.sv
verification/mips_core_tb.sv
